// ==== run.sh ====
#!/bin/sh
# compile and run the degu testbench with verilator, from the project root
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module degu_soc_tb \
  -f vlog.f -o degu_soc_sim > build.log 2>&1 \
  || { cat build.log; echo "result: build error"; exit 1; }
./obj_dir/degu_soc_sim > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// ==== tests/degu_soc_sva.sv ====
// Degu bus and UART assertions
`default_nettype none
`timescale 1ns/10ps

module degu_soc_sva (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   bus_vld,
  input logic                   bus_rdy,
  input logic                   rsp_vld,
  input degu_bus_pkg::bus_req_t bus_req,
  input logic                   uart_busy,
  input logic                   uart_txd
);

  import degu_bus_pkg::*;

  // request falls in the uart block
  logic uart_adr;

  assign uart_adr = (bus_req.adr[XLEN-1:PER_SEL_BIT+1] == '0) &&
                    bus_req.adr[PER_SEL_BIT] && bus_req.adr[UART_SEL_BIT];

  //////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////

  // accepted transfer answered next cycle
  rsp_after_xfer: assert property (@(posedge clk) disable iff (!arst_n)
    (bus_vld && bus_rdy) |=> rsp_vld)
    else $error("rsp_vld missing after an accepted transfer");

  // no response without a transfer before it
  rsp_only_after_xfer: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> $past(bus_vld && bus_rdy))
    else $error("rsp_vld without an accepted transfer");

  // only uart data writes stall
  rdy_low_only_uart: assert property (@(posedge clk) disable iff (!arst_n)
    !bus_rdy |-> (uart_adr && bus_req.wen))
    else $error("bus_rdy low outside a uart write");

  //////////////////////////////////////////////////
  // uart line
  //////////////////////////////////////////////////

  // idle line stays high
  txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
    !uart_busy |-> uart_txd)
    else $error("uart_txd low while the transmitter is idle");

endmodule

bind degu_soc_top degu_soc_sva i_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .bus_vld   (bus_vld),
  .bus_rdy   (bus_rdy),
  .rsp_vld   (rsp_vld),
  .bus_req   (bus_req),
  .uart_busy (i_uart.busy),
  .uart_txd  (uart_txd)
);

`default_nettype wire

// ==== tests/degu_soc_tb.sv ====
// Degu subsystem testbench
`default_nettype none
`timescale 1ns/10ps

module degu_soc_tb;

  import degu_bus_pkg::*;
  import degu_periph_pkg::*;

  localparam int unsigned MEM_ADR  = 6;
  localparam int unsigned GW       = 32;
  localparam int unsigned BAUD_DIV = 4;
  // run length
  localparam int N_MEM       = 16;
  localparam int N_XFER      = 2 * N_MEM + 16;
  localparam int N_FRAMES    = 3;
  localparam int TIMEOUT_CYC = N_XFER * 4 + N_FRAMES * 10 * BAUD_DIV + 200;
  // peripheral block bases
  localparam addr_t GPIO_BASE = 32'h0000_8000;
  localparam addr_t UART_BASE = 32'h0000_8040;

  logic          clk;
  logic          arst_n;
  logic          bus_vld;
  bus_req_t      bus_req;
  logic          bus_rdy;
  logic          rsp_vld;
  bus_rsp_t      bus_rsp;
  logic [GW-1:0] gpio_i;
  logic [GW-1:0] gpio_o;
  logic [GW-1:0] gpio_e;
  logic          uart_txd;

  int         errors      = 0;
  int         checks      = 0;
  int         frames_sent = 0;
  int         frames_seen = 0;
  word_t      lcg_state   = 32'd95;
  // bytes still owed on the serial line
  uart_byte_t tx_exp [$];
  // memory model and the lanes written so far
  word_t      mem_model [2**MEM_ADR];
  ben_t       mem_known [2**MEM_ADR];

  degu_soc_top #(
    .MEM_ADR  (MEM_ADR),
    .GW       (GW),
    .BAUD_DIV (BAUD_DIV)
  ) i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus_vld  (bus_vld),
    .bus_req  (bus_req),
    .bus_rdy  (bus_rdy),
    .rsp_vld  (rsp_vld),
    .bus_rsp  (bus_rsp),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e),
    .uart_txd (uart_txd)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // 32 bit lcg
  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte enables spread to a bit mask
  function automatic word_t lane_mask(input ben_t ben);
    word_t m;
    for (int b = 0; b < BLEN; b++) begin
      m[8*b +: 8] = ben[b] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  task automatic check_val(input string name, input word_t exp, input word_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // one transfer, returns in the response cycle
  task automatic bus_xfer(input logic wen, input addr_t adr, input ben_t ben,
                          input word_t wdt, output bus_rsp_t rsp, output int stalls);
    stalls = 0;
    @(negedge clk);
    bus_vld     = 1'b1;
    bus_req.wen = wen;
    bus_req.adr = adr;
    bus_req.ben = ben;
    bus_req.wdt = wdt;
    // rsp_vld marks acceptance at the edge before
    @(negedge clk);
    while (!rsp_vld) begin
      if (!bus_rdy) begin
        stalls++;
      end
      @(negedge clk);
    end
    rsp     = bus_rsp;
    bus_vld = 1'b0;
    bus_req = '0;
  endtask

  // writes answer with zero data
  task automatic bus_write(input addr_t adr, input ben_t ben, input word_t wdt,
                           input logic exp_err);
    bus_rsp_t rsp;
    int       stalls;
    bus_xfer(1'b1, adr, ben, wdt, rsp, stalls);
    check_val("bus_rsp.err", word_t'(exp_err), word_t'(rsp.err));
    check_val("bus_rsp.rdt", '0, rsp.rdt);
  endtask

  // compare only the bits under mask
  task automatic bus_read(input addr_t adr, input word_t exp, input word_t mask,
                          input logic exp_err);
    bus_rsp_t rsp;
    int       stalls;
    bus_xfer(1'b0, adr, 4'hf, '0, rsp, stalls);
    check_val("bus_rsp.err", word_t'(exp_err), word_t'(rsp.err));
    check_val("bus_rsp.rdt", exp & mask, rsp.rdt & mask);
  endtask

  // all bytes seen, then the tail of the last stop bit
  task automatic wait_frames_done();
    while (frames_seen != frames_sent) begin
      @(negedge clk);
    end
    repeat (BAUD_DIV) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // uart line monitor
  //////////////////////////////////////////////////

  initial begin : uart_monitor
    logic       prev;
    uart_byte_t got;
    uart_byte_t exp;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (arst_n && prev && !uart_txd) begin
        // to the middle of the start bit
        repeat ((BAUD_DIV - 1) / 2) @(negedge clk);
        check_val("uart_txd start bit", 32'd0, word_t'(uart_txd));
        // lsb first
        for (int i = 0; i < 8; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          got[i] = uart_txd;
        end
        repeat (BAUD_DIV) @(negedge clk);
        check_val("uart_txd stop bit", 32'd1, word_t'(uart_txd));
        if (tx_exp.size() == 0) begin
          errors++;
          $display("a uart frame appeared on the line with no byte written");
        end else begin
          exp = tx_exp.pop_front();
          check_val("uart_txd data byte", word_t'(exp), word_t'(got));
        end
        frames_seen++;
      end
      prev = uart_txd;
    end
  end

  // run limit
  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    addr_t      adr_q [$];
    addr_t      adr;
    addr_t      adr_u;
    word_t      wdt;
    ben_t       ben;
    int         idx;
    int         seen;
    int         stalls;
    bus_rsp_t   rsp;
    uart_byte_t b;
    arst_n  = 1'b0;
    bus_vld = 1'b0;
    bus_req = '0;
    gpio_i  = '0;
    for (int i = 0; i < 2**MEM_ADR; i++) begin
      mem_model[i] = '0;
      mem_known[i] = '0;
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    // reset values
    @(negedge clk);
    check_val("uart_txd", 32'd1, word_t'(uart_txd));
    check_val("gpio_o", '0, gpio_o);
    check_val("gpio_e", '0, gpio_e);
    check_val("rsp_vld", '0, word_t'(rsp_vld));

    // memory, random lanes and aliased word addresses
    for (int i = 0; i < N_MEM; i++) begin
      adr = (next_rand() >> 12) & 32'h0000_7ffc;
      wdt = next_rand();
      ben = wdt[31:28];
      wdt = next_rand();
      idx = int'(adr[MEM_ADR+1:2]);
      mem_model[idx] = (mem_model[idx] & ~lane_mask(ben)) | (wdt & lane_mask(ben));
      mem_known[idx] = mem_known[idx] | ben;
      adr_q.push_back(adr);
      bus_write(adr, ben, wdt, 1'b0);
    end
    foreach (adr_q[i]) begin
      adr = adr_q[i];
      idx = int'(adr[MEM_ADR+1:2]);
      bus_read(adr, mem_model[idx], lane_mask(mem_known[idx]), 1'b0);
    end

    // gpio output and enable
    wdt = next_rand();
    bus_write(GPIO_BASE | addr_t'(GPIO_OUT), 4'hf, wdt, 1'b0);
    check_val("gpio_o", wdt, gpio_o);
    bus_read(GPIO_BASE | addr_t'(GPIO_OUT), wdt, '1, 1'b0);
    wdt = next_rand();
    bus_write(GPIO_BASE | addr_t'(GPIO_ENA), 4'hf, wdt, 1'b0);
    check_val("gpio_e", wdt, gpio_e);
    bus_read(GPIO_BASE | addr_t'(GPIO_ENA), wdt, '1, 1'b0);
    // pins held through the synchronizer
    repeat (2) begin
      wdt = next_rand();
      gpio_i = wdt;
      repeat (3) @(negedge clk);
      bus_read(GPIO_BASE | addr_t'(GPIO_IN), wdt, '1, 1'b0);
    end

    // single uart frame
    b = uart_byte_t'(next_rand() >> 16);
    tx_exp.push_back(b);
    frames_sent++;
    bus_write(UART_BASE | addr_t'(UART_DATA), 4'h1, word_t'(b), 1'b0);
    bus_read(UART_BASE | addr_t'(UART_STAT), 32'd1, '1, 1'b0);
    wait_frames_done();
    bus_read(UART_BASE | addr_t'(UART_STAT), 32'd0, '1, 1'b0);

    // second byte written while the first is on the line
    seen = frames_seen;
    b = uart_byte_t'(next_rand() >> 16);
    tx_exp.push_back(b);
    frames_sent++;
    bus_write(UART_BASE | addr_t'(UART_DATA), 4'h1, word_t'(b), 1'b0);
    b = uart_byte_t'(next_rand() >> 16);
    tx_exp.push_back(b);
    frames_sent++;
    bus_xfer(1'b1, UART_BASE | addr_t'(UART_DATA), 4'h1, word_t'(b), rsp, stalls);
    check_val("bus_rsp.err", '0, word_t'(rsp.err));
    checks++;
    assert (stalls > 0) else begin
      errors++;
      $display("the second uart write was accepted without bus_rdy going low");
    end
    // first frame out before the second was taken
    check_val("frames on line at accept", word_t'(seen + 1), word_t'(frames_seen));
    wait_frames_done();
    bus_read(UART_BASE | addr_t'(UART_STAT), 32'd0, '1, 1'b0);

    // unmapped, aliasing a memory word
    adr = 32'h0000_0120;
    wdt = next_rand();
    bus_write(adr, 4'hf, wdt, 1'b0);
    adr_u = ((next_rand() | 32'h0001_0000) & 32'hffff_0000) | adr;
    bus_write(adr_u, 4'hf, ~wdt, 1'b1);
    bus_read(adr_u, '0, '1, 1'b1);
    bus_read(adr, wdt, '1, 1'b0);

    wait_frames_done();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/baud_timer.sv ====
// UART baud timer
`default_nettype none
`timescale 1ns/10ps

module baud_timer #(
  // clock cycles per bit
  parameter int unsigned BAUD_DIV = 434
)(
  input  logic clk,
  input  logic arst_n,
  input  logic baud_clear,
  output logic baud_tick
);

  import degu_periph_pkg::*;

  // position within the bit period
  baud_cnt_t cnt;

  // last cycle of each bit
  assign baud_tick = (cnt == baud_cnt_t'(BAUD_DIV - 1));

  // wrap on tick, restart at frame start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (baud_clear || baud_tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
// Bus address decoder
`default_nettype none
`timescale 1ns/10ps

module bus_decoder (
  input  logic                    clk,
  input  logic                    arst_n,
  // master side
  input  logic                    bus_vld,
  input  degu_bus_pkg::bus_req_t  bus_req,
  output logic                    bus_rdy,
  output degu_bus_pkg::bus_rsp_t  bus_rsp,
  // slave side
  input  logic                    uart_rdy,
  input  degu_bus_pkg::bus_rsp_t  mem_rsp,
  input  degu_bus_pkg::bus_rsp_t  gpio_rsp,
  input  degu_bus_pkg::bus_rsp_t  uart_rsp,
  output logic                    mem_vld,
  output logic                    gpio_vld,
  output logic                    uart_vld
);

  import degu_bus_pkg::*;

  // one hot region selection
  typedef struct packed {
    logic err;
    logic uart;
    logic gpio;
    logic mem;
  } sel_t;

  sel_t sel_d;
  sel_t sel_q;
  logic xfer;

  //////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////

  // upper half must be zero
  assign sel_d.err  = |bus_req.adr[XLEN-1:PER_SEL_BIT+1];
  assign sel_d.mem  = ~sel_d.err & ~bus_req.adr[PER_SEL_BIT];
  assign sel_d.gpio = ~sel_d.err &  bus_req.adr[PER_SEL_BIT] & ~bus_req.adr[UART_SEL_BIT];
  assign sel_d.uart = ~sel_d.err &  bus_req.adr[PER_SEL_BIT] &  bus_req.adr[UART_SEL_BIT];

  // only the uart can stall
  assign bus_rdy = sel_d.uart ? uart_rdy : 1'b1;
  assign xfer    = bus_vld & bus_rdy;

  // valids gated by handshake
  assign mem_vld  = xfer & sel_d.mem;
  assign gpio_vld = xfer & sel_d.gpio;
  assign uart_vld = xfer & sel_d.uart;

  //////////////////////////////////////////////////
  // response steering
  //////////////////////////////////////////////////

  // selection held for the response cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_q <= '0;
    end else begin
      sel_q <= xfer ? sel_d : '0;
    end
  end

  always_comb begin
    bus_rsp = '0;
    if (sel_q.mem) begin
      bus_rsp = mem_rsp;
    end else if (sel_q.gpio) begin
      bus_rsp = gpio_rsp;
    end else if (sel_q.uart) begin
      bus_rsp = uart_rsp;
    end else if (sel_q.err) begin
      // unmapped, no data
      bus_rsp.err = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/data_memory.sv ====
// Data memory
`default_nettype none
`timescale 1ns/10ps

module data_memory #(
  // word address width
  parameter int unsigned MEM_ADR = 10
)(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    mem_vld,
  input  degu_bus_pkg::bus_req_t  bus_req,
  output degu_bus_pkg::bus_rsp_t  mem_rsp
);

  import degu_bus_pkg::*;

  // byte offset bits below the word index
  localparam int unsigned BLOG  = $clog2(BLEN);
  localparam int unsigned DEPTH = 2**MEM_ADR;

  // storage
  word_t              mem_array [DEPTH];
  // word index, higher bits alias
  logic [MEM_ADR-1:0] widx;

  assign widx = bus_req.adr[MEM_ADR+BLOG-1:BLOG];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  // per lane write enable
  always_ff @(posedge clk) begin
    if (mem_vld && bus_req.wen) begin
      for (int b = 0; b < BLEN; b++) begin
        if (bus_req.ben[b]) begin
          mem_array[widx][8*b +: 8] <= bus_req.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // read before write, writes return zero data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_rsp <= '0;
    end else if (mem_vld) begin
      mem_rsp.rdt <= bus_req.wen ? '0 : mem_array[widx];
      mem_rsp.err <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/degu_bus_pkg.sv ====
// Degu bus definitions
`default_nettype none

package degu_bus_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // byte lanes per word
  localparam int unsigned BLEN = XLEN / 8;

  // vector types
  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [BLEN-1:0] ben_t;

  //////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////

  // request, 69 bits
  typedef struct packed {
    logic  wen;
    addr_t adr;
    ben_t  ben;
    word_t wdt;
  } bus_req_t;

  // response, 33 bits
  typedef struct packed {
    word_t rdt;
    logic  err;
  } bus_rsp_t;

  // address map select bits
  // memory when low, peripherals when high
  localparam int unsigned PER_SEL_BIT  = 15;
  // gpio when low, uart when high
  localparam int unsigned UART_SEL_BIT = 6;

endpackage

`default_nettype wire

// ==== verilog/degu_periph_pkg.sv ====
// Degu peripheral definitions
`default_nettype none

package degu_periph_pkg;

  // register offset, low address bits within a block
  typedef logic [5:0] reg_ofs_t;

  // gpio block
  localparam reg_ofs_t GPIO_OUT  = 6'h00;
  localparam reg_ofs_t GPIO_ENA  = 6'h04;
  localparam reg_ofs_t GPIO_IN   = 6'h08;

  // uart block, at 0x40
  localparam reg_ofs_t UART_DATA = 6'h00;
  localparam reg_ofs_t UART_STAT = 6'h04;

  // uart character
  typedef logic [7:0] uart_byte_t;

  // baud divisor counter, bounds the divisor
  typedef logic [15:0] baud_cnt_t;

  // transmitter states
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

`default_nettype wire

// ==== verilog/degu_soc_top.sv ====
// Degu peripheral subsystem
`default_nettype none
`timescale 1ns/10ps

module degu_soc_top #(
  // memory word address width
  parameter int unsigned MEM_ADR  = 10,
  // gpio width
  parameter int unsigned GW       = 32,
  // clock cycles per uart bit
  parameter int unsigned BAUD_DIV = 434
)(
  // system
  input  logic                    clk,
  input  logic                    arst_n,
  // external bus
  input  logic                    bus_vld,
  input  degu_bus_pkg::bus_req_t  bus_req,
  output logic                    bus_rdy,
  output logic                    rsp_vld,
  output degu_bus_pkg::bus_rsp_t  bus_rsp,
  // gpio pins
  input  logic [GW-1:0]           gpio_i,
  output logic [GW-1:0]           gpio_o,
  output logic [GW-1:0]           gpio_e,
  // uart
  output logic                    uart_txd
);

  import degu_bus_pkg::*;

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // per slave valids
  logic     mem_vld;
  logic     gpio_vld;
  logic     uart_vld;
  // uart back-pressure
  logic     uart_rdy;
  // per slave responses
  bus_rsp_t mem_rsp;
  bus_rsp_t gpio_rsp;
  bus_rsp_t uart_rsp;
  // baud timer link
  logic     baud_clear;
  logic     baud_tick;

  // response follows acceptance by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= bus_vld & bus_rdy;
    end
  end

  //////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////

  bus_decoder i_dec (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus_vld  (bus_vld),
    .bus_req  (bus_req),
    .uart_rdy (uart_rdy),
    .mem_rsp  (mem_rsp),
    .gpio_rsp (gpio_rsp),
    .uart_rsp (uart_rsp),
    .bus_rdy  (bus_rdy),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .uart_vld (uart_vld),
    .bus_rsp  (bus_rsp)
  );

  //////////////////////////////////////////////////
  // slaves
  //////////////////////////////////////////////////

  data_memory #(
    .MEM_ADR (MEM_ADR)
  ) i_mem (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_vld (mem_vld),
    .bus_req (bus_req),
    .mem_rsp (mem_rsp)
  );

  gpio_regs #(
    .GW (GW)
  ) i_gpio (
    .clk      (clk),
    .arst_n   (arst_n),
    .gpio_vld (gpio_vld),
    .bus_req  (bus_req),
    .gpio_i   (gpio_i),
    .gpio_rsp (gpio_rsp),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e)
  );

  uart_tx_fsm i_uart (
    .clk        (clk),
    .arst_n     (arst_n),
    .uart_vld   (uart_vld),
    .bus_req    (bus_req),
    .baud_tick  (baud_tick),
    .uart_rdy   (uart_rdy),
    .uart_rsp   (uart_rsp),
    .baud_clear (baud_clear),
    .uart_txd   (uart_txd)
  );

  baud_timer #(
    .BAUD_DIV (BAUD_DIV)
  ) i_baud (
    .clk        (clk),
    .arst_n     (arst_n),
    .baud_clear (baud_clear),
    .baud_tick  (baud_tick)
  );

endmodule

`default_nettype wire

// ==== verilog/gpio_regs.sv ====
// GPIO controller
`default_nettype none
`timescale 1ns/10ps

module gpio_regs #(
  // pin count
  parameter int unsigned GW = 32
)(
  input  logic                    clk,
  input  logic                    arst_n,
  // bus
  input  logic                    gpio_vld,
  input  degu_bus_pkg::bus_req_t  bus_req,
  output degu_bus_pkg::bus_rsp_t  gpio_rsp,
  // pins
  input  logic [GW-1:0]           gpio_i,
  output logic [GW-1:0]           gpio_o,
  output logic [GW-1:0]           gpio_e
);

  import degu_bus_pkg::*;
  import degu_periph_pkg::*;

  reg_ofs_t      ofs;
  word_t         wmask;
  word_t         rd_data;
  // input synchronizer stages
  logic [GW-1:0] sync_1;
  logic [GW-1:0] sync_2;

  assign ofs = bus_req.adr[$bits(reg_ofs_t)-1:0];

  // byte enables spread to bits
  always_comb begin
    for (int b = 0; b < BLEN; b++) begin
      wmask[8*b +: 8] = {8{bus_req.ben[b]}};
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (gpio_vld && bus_req.wen) begin
      // merge enabled lanes only
      if (ofs == GPIO_OUT) begin
        gpio_o <= (gpio_o & ~wmask[GW-1:0]) | (bus_req.wdt[GW-1:0] & wmask[GW-1:0]);
      end
      if (ofs == GPIO_ENA) begin
        gpio_e <= (gpio_e & ~wmask[GW-1:0]) | (bus_req.wdt[GW-1:0] & wmask[GW-1:0]);
      end
    end
  end

  // two flop input sync
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= gpio_i;
      sync_2 <= sync_1;
    end
  end

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (ofs)
      GPIO_OUT: rd_data[GW-1:0] = gpio_o;
      GPIO_ENA: rd_data[GW-1:0] = gpio_e;
      GPIO_IN:  rd_data[GW-1:0] = sync_2;
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_rsp <= '0;
    end else if (gpio_vld) begin
      gpio_rsp.rdt <= bus_req.wen ? '0 : rd_data;
      gpio_rsp.err <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_tx_fsm.sv ====
// UART transmitter
`default_nettype none
`timescale 1ns/10ps

module uart_tx_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  // bus
  input  logic                    uart_vld,
  input  degu_bus_pkg::bus_req_t  bus_req,
  output logic                    uart_rdy,
  output degu_bus_pkg::bus_rsp_t  uart_rsp,
  // baud timer
  input  logic                    baud_tick,
  output logic                    baud_clear,
  // serial line
  output logic                    uart_txd
);

  import degu_bus_pkg::*;
  import degu_periph_pkg::*;

  uart_state_t state;
  reg_ofs_t    ofs;
  uart_byte_t  tx_data;
  uart_byte_t  shift;
  logic [2:0]  bit_cnt;
  logic        busy;
  logic        start;
  word_t       rd_data;

  assign ofs   = bus_req.adr[$bits(reg_ofs_t)-1:0];
  assign busy  = (state != IDLE);
  // accepted data write opens a frame
  assign start = uart_vld & bus_req.wen & (ofs == UART_DATA);

  // stall data writes during a frame
  assign uart_rdy   = ~(bus_req.wen & (ofs == UART_DATA) & busy);
  assign baud_clear = start;

  //////////////////////////////////////////////////
  // frame sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      uart_txd <= 1'b1;
    end else begin
      case (state)
        IDLE: if (start) begin
          state    <= START;
          bit_cnt  <= '0;
          uart_txd <= 1'b0;
        end
        START: if (baud_tick) begin
          state    <= DATA;
          uart_txd <= shift[0];
        end
        DATA: if (baud_tick) begin
          if (bit_cnt == 3'd7) begin
            state    <= STOP;
            uart_txd <= 1'b1;
          end else begin
            bit_cnt  <= bit_cnt + 3'd1;
            uart_txd <= shift[1];
          end
        end
        STOP: if (baud_tick) begin
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // lsb first shifting
  always_ff @(posedge clk) begin
    if (start) begin
      tx_data <= bus_req.wdt[$bits(uart_byte_t)-1:0];
      shift   <= bus_req.wdt[$bits(uart_byte_t)-1:0];
    end else if ((state == DATA) && baud_tick) begin
      shift <= {1'b0, shift[$bits(uart_byte_t)-1:1]};
    end
  end

  //////////////////////////////////////////////////
  // register read
  //////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (ofs)
      UART_DATA: rd_data[$bits(uart_byte_t)-1:0] = tx_data;
      UART_STAT: rd_data[0] = busy;
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uart_rsp <= '0;
    end else if (uart_vld) begin
      uart_rsp.rdt <= bus_req.wen ? '0 : rd_data;
      uart_rsp.err <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/degu_bus_pkg.sv
verilog/degu_periph_pkg.sv
verilog/baud_timer.sv
verilog/uart_tx_fsm.sv
verilog/gpio_regs.sv
verilog/data_memory.sv
verilog/bus_decoder.sv
verilog/degu_soc_top.sv
tests/degu_soc_sva.sv
tests/degu_soc_tb.sv
